// ==== Makefile ====
TOP = lockstep_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// ==== list.f ====
source/lockstep_pkg.sv
source/lockstep_delay.sv
source/lockstep_reset_seq.sv
source/bus_intg_unit.sv
source/shadow_checksum.sv
source/lockstep_compare.sv
source/lockstep_top.sv
verification/tb_clock_gen.sv
verification/lockstep_asserts.sv
verification/lockstep_tb.sv

// ==== source/bus_intg_unit.sv ====
`timescale 1ns/1ns

module bus_intg_unit import lockstep_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  rvalid_i,
  input  word_t rdata_i,
  input  intg_t rdata_intg_i,
  input  word_t wdata_i,
  output intg_t wdata_intg_o,
  output logic  intg_err_o
);

  logic  rvalid_q;
  word_t rdata_q;
  intg_t rdata_intg_q;
  intg_t rdata_intg_calc;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rvalid_i;
    end
  end

  // Beat payload and its check bits
  always_ff @(posedge clk_i) begin
    rdata_q      <= rdata_i;
    rdata_intg_q <= rdata_intg_i;
  end

  //////////////////////////////////////////////////////////////////////////
  // Read check
  //////////////////////////////////////////////////////////////////////////

  assign rdata_intg_calc = intg_encode(rdata_q);
  assign intg_err_o      = rvalid_q & (rdata_intg_calc != rdata_intg_q);

  //////////////////////////////////////////////////////////////////////////
  // Write generation
  //////////////////////////////////////////////////////////////////////////

  // Same cycle as the word itself
  assign wdata_intg_o = intg_encode(wdata_i);

endmodule

// ==== source/lockstep_compare.sv ====
`timescale 1ns/1ns

module lockstep_compare import lockstep_pkg::*; #(
  parameter int unsigned LOCKSTEP_OFFSET = 2
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   cmp_en_i,
  input  word_t  core_sum_i,
  input  count_t core_cnt_i,
  input  word_t  shadow_sum_i,
  input  count_t shadow_cnt_i,
  output logic   mismatch_o
);

  // Extra cycle matches the shadow output register
  localparam int unsigned OUTPUTS_OFFSET = LOCKSTEP_OFFSET + 1;

  state_t core_state;
  state_t core_state_dly;
  state_t shadow_state_q;

  assign core_state = {core_sum_i, core_cnt_i};

  lockstep_delay #(
    .payload_t (state_t),
    .DEPTH     (OUTPUTS_OFFSET)
  ) u_core_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (core_state),
    .data_o (core_state_dly)
  );

  // Shadow state register
  always_ff @(posedge clk_i) begin
    shadow_state_q <= {shadow_sum_i, shadow_cnt_i};
  end

  assign mismatch_o = cmp_en_i & (shadow_state_q != core_state_dly);

endmodule

// ==== source/lockstep_delay.sv ====
`timescale 1ns/1ns

module lockstep_delay #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t data_i,
  output payload_t data_o
);

  // Stage 0 takes the new payload, the last stage drives the output
  payload_t stage_q [DEPTH];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= data_i;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[DEPTH-1];

endmodule

// ==== source/lockstep_pkg.sv ====
package lockstep_pkg;

  parameter int unsigned WORD_W = 32;
  parameter int unsigned INTG_W = 7;
  parameter int unsigned CNT_W  = 8;

  // Keeps an all-zero word from carrying all-zero check bits
  parameter logic [INTG_W-1:0] INTG_INVERT = 7'h2A;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [INTG_W-1:0] intg_t;
  typedef logic [CNT_W-1:0]  count_t;

  // Valid bit on top of the data word
  typedef logic [WORD_W:0] beat_t;

  // Sum on top of the beat count
  typedef logic [WORD_W+CNT_W-1:0] state_t;

  // Detect-only code over one data word
  function automatic intg_t intg_encode(input word_t data);
    intg_t code;
    code = '0;
    for (int i = 0; i < WORD_W; i++) begin
      for (int k = 0; k < 5; k++) begin
        if (i[k]) begin
          code[k] = code[k] ^ data[i];
        end
      end
    end
    // Half-word and overall parity
    code[5] = ^data[15:0];
    code[6] = ^data;
    return code ^ INTG_INVERT;
  endfunction

endpackage

// ==== source/lockstep_reset_seq.sv ====
`timescale 1ns/1ns

module lockstep_reset_seq #(
  parameter int unsigned LOCKSTEP_OFFSET = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  localparam int unsigned RST_CNT_W = $clog2(LOCKSTEP_OFFSET);

  logic [RST_CNT_W-1:0] rst_cnt_d, rst_cnt_q;
  logic                 rst_set_d, rst_set_q;
  logic                 cmp_en_q;

  // Saturates once the shadow has waited out the offset
  assign rst_set_d = (rst_cnt_q == RST_CNT_W'(LOCKSTEP_OFFSET - 1));
  assign rst_cnt_d = rst_set_d ? rst_cnt_q : (rst_cnt_q + RST_CNT_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_cnt_q <= '0;
      rst_set_q <= 1'b0;
      cmp_en_q  <= 1'b0;
    end else begin
      rst_cnt_q <= rst_cnt_d;
      rst_set_q <= rst_set_d;
      // Shadow outputs pass one more register before the compare
      cmp_en_q  <= rst_set_q;
    end
  end

  assign shadow_rst_no = rst_set_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

// ==== source/lockstep_top.sv ====
`timescale 1ns/1ns

module lockstep_top import lockstep_pkg::*; #(
  parameter int unsigned LOCKSTEP_OFFSET = 2
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   rvalid_i,
  input  word_t  rdata_i,
  input  intg_t  rdata_intg_i,
  input  word_t  core_sum_i,
  input  count_t core_cnt_i,
  output intg_t  wdata_intg_o,
  output logic   alert_major_o
);

  logic   shadow_rst_n;
  logic   cmp_en;
  logic   intg_err;
  logic   mismatch;
  beat_t  beat_in;
  beat_t  beat_dly;
  word_t  shadow_sum;
  count_t shadow_cnt;

  //////////////////////////////////////////////////////////////////////////
  // Reset sequencing
  //////////////////////////////////////////////////////////////////////////

  lockstep_reset_seq #(
    .LOCKSTEP_OFFSET (LOCKSTEP_OFFSET)
  ) u_reset_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  //////////////////////////////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////////////////////////////

  assign beat_in = {rvalid_i, rdata_i};

  lockstep_delay #(
    .payload_t (beat_t),
    .DEPTH     (LOCKSTEP_OFFSET)
  ) u_beat_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (beat_in),
    .data_o (beat_dly)
  );

  // Integrity is checked on the live beat, not the delayed one
  bus_intg_unit u_bus_intg (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rvalid_i     (rvalid_i),
    .rdata_i      (rdata_i),
    .rdata_intg_i (rdata_intg_i),
    .wdata_i      (core_sum_i),
    .wdata_intg_o (wdata_intg_o),
    .intg_err_o   (intg_err)
  );

  //////////////////////////////////////////////////////////////////////////
  // Shadow unit
  //////////////////////////////////////////////////////////////////////////

  shadow_checksum u_shadow (
    .clk_i    (clk_i),
    .rst_ni   (shadow_rst_n),
    .rvalid_i (beat_dly[WORD_W]),
    .rdata_i  (beat_dly[WORD_W-1:0]),
    .sum_o    (shadow_sum),
    .cnt_o    (shadow_cnt)
  );

  //////////////////////////////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////////////////////////////

  lockstep_compare #(
    .LOCKSTEP_OFFSET (LOCKSTEP_OFFSET)
  ) u_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmp_en_i     (cmp_en),
    .core_sum_i   (core_sum_i),
    .core_cnt_i   (core_cnt_i),
    .shadow_sum_i (shadow_sum),
    .shadow_cnt_i (shadow_cnt),
    .mismatch_o   (mismatch)
  );

  assign alert_major_o = mismatch | intg_err;

endmodule

// ==== source/shadow_checksum.sv ====
`timescale 1ns/1ns

module shadow_checksum import lockstep_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   rvalid_i,
  input  word_t  rdata_i,
  output word_t  sum_o,
  output count_t cnt_o
);

  word_t  sum_d, sum_q;
  count_t cnt_d, cnt_q;

  // Rotate left by one, fold in the beat
  always_comb begin
    sum_d = sum_q;
    cnt_d = cnt_q;
    if (rvalid_i) begin
      sum_d = {sum_q[WORD_W-2:0], sum_q[WORD_W-1]} ^ rdata_i;
      cnt_d = cnt_q + count_t'(1);
    end
  end

  // Held at zero while the shadow reset is asserted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sum_q <= '0;
      cnt_q <= '0;
    end else begin
      sum_q <= sum_d;
      cnt_q <= cnt_d;
    end
  end

  assign sum_o = sum_q;
  assign cnt_o = cnt_q;

endmodule

// ==== verification/lockstep_asserts.sv ====
`timescale 1ns/1ns

module lockstep_asserts #(
  parameter int unsigned LOCKSTEP_OFFSET = 2
) (
  input logic clk_i,
  input logic rst_ni,
  input logic alert_major_i,
  input logic shadow_rst_ni,
  input logic cmp_en_i,
  input logic mismatch_i
);

  // Saturating count of cycles since reset release
  int unsigned since_rst_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_rst_q <= 0;
    end else if (since_rst_q <= LOCKSTEP_OFFSET) begin
      since_rst_q <= since_rst_q + 1;
    end
  end

  alert_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(alert_major_i))
    else $error("alert_major_o is unknown after reset");

  // Shadow held back for the offset, then released
  shadow_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (since_rst_q < LOCKSTEP_OFFSET) |-> !shadow_rst_ni)
    else $error("shadow reset released too early");

  shadow_released_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (since_rst_q == LOCKSTEP_OFFSET) |-> shadow_rst_ni)
    else $error("shadow reset not released after the offset");

  // Comparison stays off until the shadow has had one cycle out of reset
  mismatch_gated_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (since_rst_q <= LOCKSTEP_OFFSET) |-> (!cmp_en_i && !mismatch_i))
    else $error("comparison enabled or mismatch raised before the shadow settled");

endmodule

// ==== verification/lockstep_tb.sv ====
`timescale 1ns/1ns

module lockstep_tb import lockstep_pkg::*; ();

  localparam int unsigned OFFSET        = 2;
  localparam int unsigned CLK_PERIOD_NS = 8;
  localparam int unsigned RESET_CYCLES  = 10;
  localparam int unsigned START_CYCLES  = 20;
  localparam int unsigned RANDOM_CYCLES = 400;
  localparam int unsigned N_FAULTS      = 20;
  localparam int unsigned INTG_GAP      = 5;
  localparam int unsigned LOCK_GAP      = 7;
  localparam int unsigned DRAIN_CYCLES  = 8;
  localparam int unsigned TOTAL_CYCLES  = RESET_CYCLES + START_CYCLES + RANDOM_CYCLES
                                          + 2 * N_FAULTS * INTG_GAP + N_FAULTS * LOCK_GAP
                                          + DRAIN_CYCLES;
  localparam int unsigned WATCHDOG_NS   = (TOTAL_CYCLES + 100) * CLK_PERIOD_NS;
  localparam intg_t       CODE_INVERT   = 7'h2A;

  logic   clk;
  logic   rst_n;
  logic   rvalid;
  word_t  rdata;
  intg_t  rdata_intg;
  word_t  core_sum;
  count_t core_cnt;
  intg_t  wdata_intg;
  logic   alert_major;

  // Main-unit model state
  word_t  model_sum;
  count_t model_cnt;

  // Bit 0 is the expected alert of the current cycle
  logic [7:0]  alert_sched;
  int unsigned intg_errors;
  int unsigned alert_errors;
  string       test_name;

  tb_clock_gen #(
    .PERIOD_NS (CLK_PERIOD_NS)
  ) u_clock_gen (
    .clk_o (clk)
  );

  lockstep_top #(
    .LOCKSTEP_OFFSET (OFFSET)
  ) UUT (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .rvalid_i      (rvalid),
    .rdata_i       (rdata),
    .rdata_intg_i  (rdata_intg),
    .core_sum_i    (core_sum),
    .core_cnt_i    (core_cnt),
    .wdata_intg_o  (wdata_intg),
    .alert_major_o (alert_major)
  );

  bind lockstep_top lockstep_asserts #(
    .LOCKSTEP_OFFSET (LOCKSTEP_OFFSET)
  ) u_asserts (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .alert_major_i (alert_major_o),
    .shadow_rst_ni (shadow_rst_n),
    .cmp_en_i      (cmp_en),
    .mismatch_i    (mismatch)
  );

  // Check bits 0 to 4 cover the data bits whose index has that bit set
  function automatic intg_t expected_code(input word_t data);
    intg_t code;
    code = '0;
    for (int k = 0; k < 5; k++) begin
      for (int i = 0; i < 32; i++) begin
        if (((i >> k) & 1) == 1) begin
          code[k] = code[k] ^ data[i];
        end
      end
    end
    code[5] = ^data[15:0];
    code[6] = ^data;
    return code ^ CODE_INVERT;
  endfunction

  function automatic logic random_valid();
    return ($urandom % 4) != 0;
  endfunction

  task automatic check_intg(input intg_t expected, input intg_t actual);
    if (actual !== expected) begin
      intg_errors++;
      $display("ERROR %s: wdata_intg_o expected %h, actual %h at %0t ns",
               test_name, expected, actual, $time);
    end
  endtask

  task automatic check_alert(input logic expected, input logic actual);
    if (actual !== expected) begin
      alert_errors++;
      $display("ERROR %s: alert_major_o expected %b, actual %b at %0t ns",
               test_name, expected, actual, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One clock cycle of stimulus and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_cycle(input logic rst_val, input logic valid, input intg_t intg_flip,
                           input word_t sum_flip, input count_t cnt_flip);
    word_t data;
    @(posedge clk);
    // Model takes the beat of the cycle that just ended
    if (!rst_n) begin
      model_sum = '0;
      model_cnt = '0;
    end else if (rvalid) begin
      model_sum = {model_sum[WORD_W-2:0], model_sum[WORD_W-1]} ^ rdata;
      model_cnt = model_cnt + count_t'(1);
    end
    alert_sched = alert_sched >> 1;
    data = $urandom;
    rst_n      <= rst_val;
    rvalid     <= valid;
    rdata      <= data;
    rdata_intg <= expected_code(data) ^ intg_flip;
    core_sum   <= model_sum ^ sum_flip;
    core_cnt   <= model_cnt ^ cnt_flip;
    if (valid && (intg_flip != '0)) begin
      alert_sched[1] = 1'b1;
    end
    if ((sum_flip != '0) || (cnt_flip != '0)) begin
      alert_sched[OFFSET+1] = 1'b1;
    end
    @(negedge clk);
    check_intg(expected_code(core_sum), wdata_intg);
    check_alert(alert_sched[0], alert_major);
  endtask

  task automatic clean_cycles(input int unsigned n);
    repeat (n) run_cycle(1'b1, random_valid(), '0, '0, '0);
  endtask

  initial begin
    intg_t  intg_flip;
    word_t  sum_flip;
    count_t cnt_flip;
    void'($urandom(32'h173c_856d));
    rst_n        = 1'b0;
    rvalid       = 1'b0;
    rdata        = '0;
    rdata_intg   = expected_code('0);
    core_sum     = '0;
    core_cnt     = '0;
    model_sum    = '0;
    model_cnt    = '0;
    alert_sched  = '0;
    intg_errors  = 0;
    alert_errors = 0;

    test_name = "reset";
    repeat (RESET_CYCLES) run_cycle(1'b0, 1'b0, '0, '0, '0);

    // Dense beats right from the release edge
    test_name = "clean_start";
    repeat (START_CYCLES) run_cycle(1'b1, 1'b1, '0, '0, '0);

    test_name = "clean_random";
    clean_cycles(RANDOM_CYCLES);

    test_name = "intg_fault_valid";
    for (int i = 0; i < N_FAULTS; i++) begin
      intg_flip = intg_t'(1) << ($urandom % INTG_W);
      run_cycle(1'b1, 1'b1, intg_flip, '0, '0);
      clean_cycles(INTG_GAP - 1);
    end

    test_name = "intg_fault_idle";
    for (int i = 0; i < N_FAULTS; i++) begin
      intg_flip = intg_t'(1) << ($urandom % INTG_W);
      run_cycle(1'b1, 1'b0, intg_flip, '0, '0);
      clean_cycles(INTG_GAP - 1);
    end

    // Only the driven state is corrupted while the model stays correct
    test_name = "lockstep_mismatch";
    for (int i = 0; i < N_FAULTS; i++) begin
      sum_flip = '0;
      cnt_flip = '0;
      if (i % 2 == 0) begin
        sum_flip = word_t'(1) << ($urandom % WORD_W);
      end else begin
        cnt_flip = count_t'(1) << ($urandom % CNT_W);
      end
      run_cycle(1'b1, random_valid(), '0, sum_flip, cnt_flip);
      clean_cycles(LOCK_GAP - 1);
    end

    test_name = "drain";
    clean_cycles(DRAIN_CYCLES);

    $display("Checks done: %0d wdata_intg errors, %0d alert errors",
             intg_errors, alert_errors);
    if ((intg_errors + alert_errors) == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS = 8
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule
